// ==== Bender.yml ====
package:
  name: periph_subsystem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/periph_pkg.sv
      - gpio/gpio_port.sv
      - timer/interval_timer.sv
      - verilog/periph_decoder.sv
      - verilog/irq_controller.sv
      - verilog/periph_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_periph_top.sv

// ==== all.f ====
+incdir+common
common/periph_pkg.sv
gpio/gpio_port.sv
timer/interval_timer.sv
verilog/periph_decoder.sv
verilog/irq_controller.sv
verilog/periph_top.sv
dv/tb_periph_top.sv

// ==== common/periph_params.svh ====
// bus widths, slave select codes and register offsets of the peripheral subsystem
// include wherever a module decodes addresses or sizes its ports
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// ----------------------------------------
// bus geometry
// ----------------------------------------
// word address, upper two bits pick the slave, lower two the register
`define PERIPH_ADR_WIDTH	4
`define PERIPH_DAT_WIDTH	32
`define GPIO_PORT_WIDTH		8

// slave select codes, code 3 is unmapped
`define SEL_GPIO			2'd0
`define SEL_TIMER			2'd1
`define SEL_IRQ				2'd2

// ----------------------------------------
// register offsets
// ----------------------------------------
`define GPIO_REG_DIRECTION	2'd0
`define GPIO_REG_INPUT		2'd1
`define GPIO_REG_OUTPUT		2'd2
`define GPIO_REG_RISE_MASK	2'd3

`define TIMER_REG_CONTROL	2'd0
`define TIMER_REG_COMPARE	2'd1
`define TIMER_REG_COUNT		2'd2

`define IRQ_REG_PENDING		2'd0
`define IRQ_REG_ENABLE		2'd1
`define IRQ_REG_STATUS		2'd2

// interrupt source bit positions
`define IRQ_SRC_GPIO		0
`define IRQ_SRC_TIMER		1

`endif

// ==== common/periph_pkg.sv ====
// shared types of the peripheral subsystem
// modules refer to these by scoped name in ports and import them in the body
`include "periph_params.svh"

package periph_pkg;

	// ----------------------------------------
	// bus side
	// ----------------------------------------
	typedef logic [`PERIPH_ADR_WIDTH-1:0] wb_adr_t;
	typedef logic [`PERIPH_DAT_WIDTH-1:0] wb_dat_t;

	// register offset inside one slave
	typedef logic [1:0] reg_ofs_t;

	// ----------------------------------------
	// slave side
	// ----------------------------------------
	// one bit per interrupt source, gpio and timer
	typedef logic [1:0] irq_vec_t;

	// timer counter and compare value
	typedef logic [31:0] timer_cnt_t;

endpackage

// ==== dv/tb_periph_top.sv ====
// testbench for the peripheral subsystem with random bus and pin traffic checked against a model
// compile with all.f and elaborate tb_periph_top as the top module
`timescale 1ns/1ps
`include "periph_params.svh"

module tb_periph_top;

	import periph_pkg::*;

	localparam int PW      = `GPIO_PORT_WIDTH;
	localparam int TIMEOUT = 200;

	logic          clk;
	logic          reset;
	wb_adr_t       wb_adr;
	wb_dat_t       wb_dat_wr;
	logic          wb_we;
	logic          wb_stb;
	wb_dat_t       wb_dat_rd;
	logic          wb_ack;
	wire [PW-1:0]  port_io;
	logic          irq;

	// testbench side of the pins
	logic [PW-1:0] pin_drive_en;
	logic [PW-1:0] pin_level;
	logic [15:0]   lfsr;

	// register model
	logic [PW-1:0] m_dir;
	logic [PW-1:0] m_out;
	logic [PW-1:0] m_mask;
	irq_vec_t      m_irq_en;

	periph_top DUT (
		.clk      (clk),
		.reset    (reset),
		.wb_adr_i (wb_adr),
		.wb_dat_i (wb_dat_wr),
		.wb_we_i  (wb_we),
		.wb_stb_i (wb_stb),
		.wb_dat_o (wb_dat_rd),
		.wb_ack_o (wb_ack),
		.port_io  (port_io),
		.irq_o    (irq)
	);

	genvar i;
	generate
		for (i = 0; i < PW; i++) begin : g_pin_drv
			assign port_io[i] = pin_drive_en[i] ? pin_level[i] : 1'bz;
		end
	endgenerate

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ----------------------------------------
	// helpers
	// ----------------------------------------
	// 16-bit fibonacci lfsr with taps 16 14 13 11
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	function automatic wb_adr_t make_addr(input logic [1:0] sel, input logic [1:0] ofs);
		return {sel, ofs};
	endfunction

	// level seen on the pins and so in the input register
	function automatic logic [PW-1:0] pin_expected();
		return (m_dir & m_out) | (~m_dir & pin_level);
	endfunction

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			report_failure($sformatf("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h",
				$time, name, got, exp));
		end
	endtask

	task automatic step(input int n);
		repeat (n) @(negedge clk);
	endtask

	// one bus cycle that starts and ends on a falling edge
	task automatic bus_cycle(input wb_adr_t adr, input logic we, input wb_dat_t dat,
		output wb_dat_t rdat);
		int waited;
		wb_adr    = adr;
		wb_we     = we;
		wb_dat_wr = dat;
		wb_stb    = 1'b1;
		waited    = 0;
		#1;
		while (!wb_ack) begin
			if (waited == TIMEOUT) begin
				report_failure("Timeout waiting for the bus acknowledge");
			end
			@(negedge clk);
			#1;
			waited++;
		end
		// zero-wait bus
		assert (waited == 0) else begin
			report_failure("Bus acknowledge did not come in the strobe cycle");
		end
		rdat = wb_dat_rd;
		@(negedge clk);
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic bus_write(input logic [1:0] sel, input logic [1:0] ofs, input wb_dat_t dat);
		wb_dat_t ignored_dat;
		bus_cycle(make_addr(sel, ofs), 1'b1, dat, ignored_dat);
	endtask

	task automatic read_check(input logic [1:0] sel, input logic [1:0] ofs,
		input wb_dat_t exp, input string name);
		wb_dat_t got;
		bus_cycle(make_addr(sel, ofs), 1'b0, '0, got);
		check_eq(name, got, exp);
	endtask

	// pins change hands without both sides driving at once
	task automatic set_direction(input logic [PW-1:0] dir);
		pin_drive_en = pin_drive_en & ~dir;
		bus_write(`SEL_GPIO, `GPIO_REG_DIRECTION, dir);
		m_dir        = dir;
		pin_drive_en = ~dir;
	endtask

	task automatic wait_irq(output int edges);
		edges = 0;
		while (irq !== 1'b1) begin
			if (edges == TIMEOUT) begin
				report_failure("Timeout waiting for irq_o to rise");
			end
			@(negedge clk);
			edges++;
		end
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		int          kind;
		int          edges;
		wb_dat_t     data;
		timer_cnt_t  cmp;
		logic [2:0]  bit_sel;
		logic [2:0]  other_bit;

		reset        = 1'b1;
		wb_adr       = '0;
		wb_dat_wr    = '0;
		wb_we        = 1'b0;
		wb_stb       = 1'b0;
		pin_drive_en = '0;
		pin_level    = '0;
		lfsr         = 16'd29;
		m_dir        = '0;
		m_out        = '0;
		m_mask       = '0;
		m_irq_en     = '0;
		repeat (2) @(negedge clk);
		reset = 1'b0;

		// reset values
		assert (port_io === {PW{1'bz}}) else begin
			report_failure("A GPIO pin is driven right after reset");
		end
		check_eq("irq_o", irq, 1'b0);
		check_eq("wb_ack_o", wb_ack, 1'b0);
		pin_drive_en = '1;
		step(1);
		for (int a = 0; a < 16; a++) begin
			read_check(a[3:2], a[1:0], '0, $sformatf("wb_dat_o at address %0d", a));
		end

		// random register readback
		for (int n = 0; n < 24; n++) begin
			kind = rand_bits(3) % 5;
			data = rand_bits(32);
			case (kind)
				0: begin
					set_direction(data[PW-1:0]);
					read_check(`SEL_GPIO, `GPIO_REG_DIRECTION, m_dir, "wb_dat_o gpio direction");
				end
				1: begin
					m_out = data[PW-1:0];
					bus_write(`SEL_GPIO, `GPIO_REG_OUTPUT, data);
					read_check(`SEL_GPIO, `GPIO_REG_OUTPUT, m_out, "wb_dat_o gpio output");
				end
				2: begin
					m_mask = data[PW-1:0];
					bus_write(`SEL_GPIO, `GPIO_REG_RISE_MASK, data);
					read_check(`SEL_GPIO, `GPIO_REG_RISE_MASK, m_mask, "wb_dat_o gpio mask");
				end
				3: begin
					bus_write(`SEL_TIMER, `TIMER_REG_COMPARE, data);
					read_check(`SEL_TIMER, `TIMER_REG_COMPARE, data, "wb_dat_o timer compare");
				end
				default: begin
					m_irq_en = data[1:0];
					bus_write(`SEL_IRQ, `IRQ_REG_ENABLE, data);
					read_check(`SEL_IRQ, `IRQ_REG_ENABLE, m_irq_en, "wb_dat_o irq enable");
				end
			endcase
		end
		read_check(`SEL_TIMER, 2'd3, '0, "wb_dat_o timer offset 3");
		read_check(`SEL_IRQ, 2'd3, '0, "wb_dat_o irq offset 3");
		for (int a = 0; a < 4; a++) begin
			read_check(2'd3, a[1:0], '0, $sformatf("wb_dat_o unmapped offset %0d", a));
		end

		// quiet the edge detector and drop stray events
		m_mask   = '0;
		m_irq_en = '0;
		bus_write(`SEL_GPIO, `GPIO_REG_RISE_MASK, '0);
		bus_write(`SEL_IRQ, `IRQ_REG_ENABLE, '0);
		step(3);
		bus_write(`SEL_IRQ, `IRQ_REG_PENDING, 32'd3);
		read_check(`SEL_IRQ, `IRQ_REG_PENDING, '0, "wb_dat_o irq pending");

		// pin behavior
		for (int n = 0; n < 8; n++) begin
			set_direction(rand_bits(PW));
			m_out = rand_bits(PW);
			bus_write(`SEL_GPIO, `GPIO_REG_OUTPUT, m_out);
			check_eq("port_io", port_io, pin_expected());
			pin_level = rand_bits(PW);
			step(1);
			read_check(`SEL_GPIO, `GPIO_REG_INPUT, pin_expected(), "wb_dat_o gpio input");
		end

		// ----------------------------------------
		// gpio interrupt
		// ----------------------------------------
		set_direction('0);
		pin_level = '0;
		step(3);
		bus_write(`SEL_IRQ, `IRQ_REG_PENDING, 32'd3);
		bit_sel   = rand_bits(3);
		other_bit = bit_sel + 3'd1;
		m_mask    = '0;
		m_mask[bit_sel] = 1'b1;
		bus_write(`SEL_GPIO, `GPIO_REG_RISE_MASK, m_mask);
		m_irq_en  = 2'b01;
		bus_write(`SEL_IRQ, `IRQ_REG_ENABLE, m_irq_en);
		check_eq("irq_o", irq, 1'b0);
		pin_level[bit_sel] = 1'b1;
		wait_irq(edges);
		check_eq("edges from pin rise to irq_o", edges, 3);
		read_check(`SEL_IRQ, `IRQ_REG_PENDING, 32'd1, "wb_dat_o irq pending");
		read_check(`SEL_IRQ, `IRQ_REG_STATUS, 32'd1, "wb_dat_o irq status");
		// enable gates the line but not the pending bit
		bus_write(`SEL_IRQ, `IRQ_REG_ENABLE, '0);
		check_eq("irq_o", irq, 1'b0);
		read_check(`SEL_IRQ, `IRQ_REG_STATUS, '0, "wb_dat_o irq status");
		read_check(`SEL_IRQ, `IRQ_REG_PENDING, 32'd1, "wb_dat_o irq pending");
		bus_write(`SEL_IRQ, `IRQ_REG_ENABLE, 32'd1);
		check_eq("irq_o", irq, 1'b1);
		bus_write(`SEL_IRQ, `IRQ_REG_PENDING, 32'd1);
		check_eq("irq_o", irq, 1'b0);
		read_check(`SEL_IRQ, `IRQ_REG_PENDING, '0, "wb_dat_o irq pending");
		// unmasked rise and masked fall raise nothing
		pin_level[other_bit] = 1'b1;
		pin_level[bit_sel]   = 1'b0;
		step(5);
		read_check(`SEL_IRQ, `IRQ_REG_PENDING, '0, "wb_dat_o irq pending");

		// ----------------------------------------
		// timer
		// ----------------------------------------
		m_mask = '0;
		bus_write(`SEL_GPIO, `GPIO_REG_RISE_MASK, '0);
		cmp = 2 + rand_bits(3);
		bus_write(`SEL_TIMER, `TIMER_REG_COMPARE, cmp);
		m_irq_en = 2'b10;
		bus_write(`SEL_IRQ, `IRQ_REG_ENABLE, m_irq_en);
		bus_write(`SEL_IRQ, `IRQ_REG_PENDING, 32'd3);
		bus_write(`SEL_TIMER, `TIMER_REG_CONTROL, 32'd3);
		wait_irq(edges);
		check_eq("edges from timer start to irq_o", edges, cmp + 2);
		for (int n = 0; n < 3; n++) begin
			bus_write(`SEL_IRQ, `IRQ_REG_PENDING, 32'd2);
			wait_irq(edges);
			// the clear write itself spends one edge
			check_eq("timer tick period", edges + 1, cmp + 1);
		end

		// one-shot
		bus_write(`SEL_TIMER, `TIMER_REG_CONTROL, '0);
		bus_write(`SEL_TIMER, `TIMER_REG_COUNT, '0);
		bus_write(`SEL_IRQ, `IRQ_REG_PENDING, 32'd3);
		read_check(`SEL_IRQ, `IRQ_REG_PENDING, '0, "wb_dat_o irq pending");
		bus_write(`SEL_TIMER, `TIMER_REG_CONTROL, 32'd1);
		wait_irq(edges);
		check_eq("edges from one-shot start to irq_o", edges, cmp + 2);
		bus_write(`SEL_IRQ, `IRQ_REG_PENDING, 32'd2);
		for (int n = 0; n < 3 * (cmp + 1); n++) begin
			step(1);
			check_eq("irq_o after one-shot", irq, 1'b0);
		end
		read_check(`SEL_TIMER, `TIMER_REG_CONTROL, '0, "wb_dat_o timer control");
		read_check(`SEL_TIMER, `TIMER_REG_COUNT, '0, "wb_dat_o timer count");

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== gpio/gpio_port.sv ====
// bidirectional gpio block with direction, output and rise-mask registers
// pins are sampled every cycle and a masked rising edge gives a one-cycle pulse
`timescale 1ns/1ps
`include "periph_params.svh"

module gpio_port #(
	parameter int PORT_WIDTH = `GPIO_PORT_WIDTH
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                stb_i,
	input  logic                we_i,
	input  periph_pkg::reg_ofs_t ofs_i,
	input  periph_pkg::wb_dat_t  dat_i,
	output periph_pkg::wb_dat_t  dat_o,
	inout  wire [PORT_WIDTH-1:0] port_io,
	output logic                rise_o
);

	logic [PORT_WIDTH-1:0] reg_direction;
	logic [PORT_WIDTH-1:0] reg_output;
	logic [PORT_WIDTH-1:0] reg_rise_mask;
	logic [PORT_WIDTH-1:0] reg_input;
	logic [PORT_WIDTH-1:0] reg_input_d;
	logic                  wr_en;
	logic                  rise_any;

	assign wr_en = stb_i && we_i;

	// ----------------------------------------
	// control registers and pin sampling
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_direction <= '0;
			reg_output    <= '0;
			reg_rise_mask <= '0;
			reg_input     <= '0;
			reg_input_d   <= '0;
		end else begin
			if (wr_en && ofs_i == `GPIO_REG_DIRECTION) begin
				reg_direction <= dat_i[PORT_WIDTH-1:0];
			end
			if (wr_en && ofs_i == `GPIO_REG_OUTPUT) begin
				reg_output <= dat_i[PORT_WIDTH-1:0];
			end
			if (wr_en && ofs_i == `GPIO_REG_RISE_MASK) begin
				reg_rise_mask <= dat_i[PORT_WIDTH-1:0];
			end
			// single sample stage, previous sample kept for edge detect
			reg_input   <= port_io;
			reg_input_d <= reg_input;
		end
	end

	// rising edge on any masked bit of the sampled input
	assign rise_any = |(reg_input & ~reg_input_d & reg_rise_mask);

	always_ff @(posedge clk) begin
		if (reset) begin
			rise_o <= 1'b0;
		end else begin
			rise_o <= rise_any;
		end
	end

	// ----------------------------------------
	// pin drivers
	// ----------------------------------------
	genvar i;
	generate
		for (i = 0; i < PORT_WIDTH; i++) begin : g_pin
			assign port_io[i] = reg_direction[i] ? reg_output[i] : 1'bz;
		end
	endgenerate

	// read back, zero extended to the bus width
	always_comb begin
		dat_o = '0;
		case (ofs_i)
			`GPIO_REG_DIRECTION: dat_o[PORT_WIDTH-1:0] = reg_direction;
			`GPIO_REG_INPUT:     dat_o[PORT_WIDTH-1:0] = reg_input;
			`GPIO_REG_OUTPUT:    dat_o[PORT_WIDTH-1:0] = reg_output;
			`GPIO_REG_RISE_MASK: dat_o[PORT_WIDTH-1:0] = reg_rise_mask;
			default:             dat_o = '0;
		endcase
	end

endmodule

// ==== timer/interval_timer.sv ====
// interval timer counting up to a compare value, then ticking and restarting
// control bit 0 enables, bit 1 selects auto-reload, otherwise the timer is one-shot
`timescale 1ns/1ps
`include "periph_params.svh"

module interval_timer (
	input  logic                clk,
	input  logic                reset,
	input  logic                stb_i,
	input  logic                we_i,
	input  periph_pkg::reg_ofs_t ofs_i,
	input  periph_pkg::wb_dat_t  dat_i,
	output periph_pkg::wb_dat_t  dat_o,
	output logic                tick_o
);

	import periph_pkg::*;

	logic       ctrl_enable;
	logic       ctrl_reload;
	timer_cnt_t count;
	timer_cnt_t compare;
	logic       wr_en;
	logic       hit;

	assign wr_en = stb_i && we_i;

	// counter reached compare while running
	assign hit = ctrl_enable && (count == compare);

	// ----------------------------------------
	// control and compare registers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_enable <= 1'b0;
			ctrl_reload <= 1'b0;
			compare     <= '0;
		end else begin
			// one-shot stops itself on the hit
			if (hit && !ctrl_reload) begin
				ctrl_enable <= 1'b0;
			end
			// a control write in the same cycle takes priority
			if (wr_en && ofs_i == `TIMER_REG_CONTROL) begin
				ctrl_enable <= dat_i[0];
				ctrl_reload <= dat_i[1];
			end
			if (wr_en && ofs_i == `TIMER_REG_COMPARE) begin
				compare <= dat_i;
			end
		end
	end

	// ----------------------------------------
	// counter and tick
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			count  <= '0;
			tick_o <= 1'b0;
		end else begin
			tick_o <= 1'b0;
			if (wr_en && ofs_i == `TIMER_REG_COUNT) begin
				// software load beats the increment
				count <= dat_i;
			end else if (hit) begin
				count  <= '0;
				tick_o <= 1'b1;
			end else if (ctrl_enable) begin
				count <= count + 1'b1;
			end
		end
	end

	always_comb begin
		dat_o = '0;
		case (ofs_i)
			`TIMER_REG_CONTROL: dat_o[1:0] = {ctrl_reload, ctrl_enable};
			`TIMER_REG_COMPARE: dat_o = compare;
			`TIMER_REG_COUNT:   dat_o = count;
			default:            dat_o = '0;
		endcase
	end

endmodule

// ==== verilog/irq_controller.sv ====
// interrupt controller collecting event pulses into one level interrupt
// pending is write-one-to-clear, status shows pending bits that are enabled
`timescale 1ns/1ps
`include "periph_params.svh"

module irq_controller (
	input  logic                clk,
	input  logic                reset,
	input  logic                stb_i,
	input  logic                we_i,
	input  periph_pkg::reg_ofs_t ofs_i,
	input  periph_pkg::wb_dat_t  dat_i,
	output periph_pkg::wb_dat_t  dat_o,
	input  periph_pkg::irq_vec_t src_i,
	output logic                irq_o
);

	import periph_pkg::*;

	localparam int NUM_SRC = $bits(irq_vec_t);

	irq_vec_t reg_pending;
	irq_vec_t reg_enable;
	irq_vec_t clear_mask;
	irq_vec_t status;
	logic     wr_en;

	assign wr_en = stb_i && we_i;

	// ones written to pending clear those bits
	assign clear_mask = (wr_en && ofs_i == `IRQ_REG_PENDING) ? dat_i[NUM_SRC-1:0] : '0;

	// ----------------------------------------
	// pending and enable registers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_pending <= '0;
			reg_enable  <= '0;
		end else begin
			// new event wins over a clear in the same cycle
			reg_pending <= (reg_pending & ~clear_mask) | src_i;
			if (wr_en && ofs_i == `IRQ_REG_ENABLE) begin
				reg_enable <= dat_i[NUM_SRC-1:0];
			end
		end
	end

	assign status = reg_pending & reg_enable;
	assign irq_o  = |status;

	always_comb begin
		dat_o = '0;
		case (ofs_i)
			`IRQ_REG_PENDING: dat_o[NUM_SRC-1:0] = reg_pending;
			`IRQ_REG_ENABLE:  dat_o[NUM_SRC-1:0] = reg_enable;
			`IRQ_REG_STATUS:  dat_o[NUM_SRC-1:0] = status;
			default:          dat_o = '0;
		endcase
	end

endmodule

// ==== verilog/periph_decoder.sv ====
// bus decoder for the peripheral subsystem
// splits the strobe by slave select and multiplexes the read data back
`timescale 1ns/1ps
`include "periph_params.svh"

module periph_decoder (
	input  periph_pkg::wb_adr_t wb_adr_i,
	input  logic               wb_stb_i,
	input  periph_pkg::wb_dat_t gpio_dat_i,
	input  periph_pkg::wb_dat_t timer_dat_i,
	input  periph_pkg::wb_dat_t irq_dat_i,
	output logic               gpio_stb_o,
	output logic               timer_stb_o,
	output logic               irq_stb_o,
	output periph_pkg::wb_dat_t wb_dat_o,
	output logic               wb_ack_o
);

	logic [1:0] slave_sel;

	// top two address bits pick the slave
	assign slave_sel = wb_adr_i[`PERIPH_ADR_WIDTH-1 -: 2];

	// ----------------------------------------
	// strobe fan-out
	// ----------------------------------------
	assign gpio_stb_o  = wb_stb_i && (slave_sel == `SEL_GPIO);
	assign timer_stb_o = wb_stb_i && (slave_sel == `SEL_TIMER);
	assign irq_stb_o   = wb_stb_i && (slave_sel == `SEL_IRQ);

	// ----------------------------------------
	// read data return
	// ----------------------------------------
	always_comb begin
		case (slave_sel)
			`SEL_GPIO:  wb_dat_o = gpio_dat_i;
			`SEL_TIMER: wb_dat_o = timer_dat_i;
			`SEL_IRQ:   wb_dat_o = irq_dat_i;
			// unmapped select reads as zero
			default:    wb_dat_o = '0;
		endcase
	end

	// zero-wait slaves, every strobe is answered at once
	assign wb_ack_o = wb_stb_i;

endmodule

// ==== verilog/periph_top.sv ====
// top level of the peripheral subsystem behind one zero-wait bus slave port
// connects the decoder to the gpio, timer and interrupt controller
`timescale 1ns/1ps
`include "periph_params.svh"

module periph_top (
	input  logic                       clk,
	input  logic                       reset,
	input  periph_pkg::wb_adr_t        wb_adr_i,
	input  periph_pkg::wb_dat_t        wb_dat_i,
	input  logic                       wb_we_i,
	input  logic                       wb_stb_i,
	output periph_pkg::wb_dat_t        wb_dat_o,
	output logic                       wb_ack_o,
	inout  wire [`GPIO_PORT_WIDTH-1:0] port_io,
	output logic                       irq_o
);

	import periph_pkg::*;

	reg_ofs_t reg_ofs;
	wb_dat_t  gpio_dat;
	wb_dat_t  timer_dat;
	wb_dat_t  irq_dat;
	logic     gpio_stb;
	logic     timer_stb;
	logic     irq_stb;
	logic     gpio_rise;
	logic     timer_tick;
	irq_vec_t irq_src;

	// low address bits select the register inside each slave
	assign reg_ofs = wb_adr_i[1:0];

	assign irq_src[`IRQ_SRC_GPIO]  = gpio_rise;
	assign irq_src[`IRQ_SRC_TIMER] = timer_tick;

	periph_decoder u_decoder (
		.wb_adr_i    (wb_adr_i),
		.wb_stb_i    (wb_stb_i),
		.gpio_dat_i  (gpio_dat),
		.timer_dat_i (timer_dat),
		.irq_dat_i   (irq_dat),
		.gpio_stb_o  (gpio_stb),
		.timer_stb_o (timer_stb),
		.irq_stb_o   (irq_stb),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o)
	);

	gpio_port #(
		.PORT_WIDTH (`GPIO_PORT_WIDTH)
	) u_gpio (
		.clk     (clk),
		.reset   (reset),
		.stb_i   (gpio_stb),
		.we_i    (wb_we_i),
		.ofs_i   (reg_ofs),
		.dat_i   (wb_dat_i),
		.dat_o   (gpio_dat),
		.port_io (port_io),
		.rise_o  (gpio_rise)
	);

	interval_timer u_timer (
		.clk    (clk),
		.reset  (reset),
		.stb_i  (timer_stb),
		.we_i   (wb_we_i),
		.ofs_i  (reg_ofs),
		.dat_i  (wb_dat_i),
		.dat_o  (timer_dat),
		.tick_o (timer_tick)
	);

	irq_controller u_irq (
		.clk   (clk),
		.reset (reset),
		.stb_i (irq_stb),
		.we_i  (wb_we_i),
		.ofs_i (reg_ofs),
		.dat_i (wb_dat_i),
		.dat_o (irq_dat),
		.src_i (irq_src),
		.irq_o (irq_o)
	);

endmodule
